/* design/mlse_cfg_pkg.sv */
package mlse_cfg_pkg;

    // symbol alphabet. Four amplitude levels carried as a 2-bit index.
    localparam int SYM_BITS = 2;
    localparam int N_SYM    = 1 << SYM_BITS;

    // channel memory sets the trellis size.
    localparam int N_TAPS   = 2;
    localparam int N_STATES = N_SYM ** (N_TAPS - 1);

    localparam int HIST_DEPTH = 16; // survivor length, also the decision delay.

    localparam int SAMPLE_W = 12;   // signed received sample.
    localparam int TAP_W    = 8;    // signed channel tap.
    localparam int LEVEL_W  = 3;    // signed symbol level from -3 to +3.

    localparam int ENERGY_W = 24;
    localparam logic [ENERGY_W-1:0] ENERGY_MAX = '1;

    // counts accepted samples up to HIST_DEPTH.
    localparam int FILL_W = $clog2(HIST_DEPTH + 1);

endpackage

/* design/mlse_types_pkg.sv */
package mlse_types_pkg;

    // codes 0 to 3 stand for levels -3, -1, +1 and +3.
    typedef logic [mlse_cfg_pkg::SYM_BITS-1:0] symbol_t;

    typedef logic signed [mlse_cfg_pkg::LEVEL_W-1:0]  level_t;
    typedef logic signed [mlse_cfg_pkg::SAMPLE_W-1:0] sample_t;
    typedef logic signed [mlse_cfg_pkg::TAP_W-1:0]    tap_t;
    typedef logic [mlse_cfg_pkg::ENERGY_W-1:0]        energy_t;

    // tap 0 weights the newest symbol.
    typedef tap_t [mlse_cfg_pkg::N_TAPS-1:0] chan_est_t;

    // entry 0 is the newest symbol of a survivor.
    typedef symbol_t [mlse_cfg_pkg::HIST_DEPTH-1:0] history_t;

    // survivor without its energy, carried through the path selector.
    typedef struct packed {
        history_t hist;
        symbol_t  src;
    } survivor_t;

    typedef struct packed {
        energy_t  energy;
        history_t hist;
        symbol_t  src;     // state the path came from.
    } path_t;

    typedef struct packed {
        symbol_t sym;
        energy_t energy;
    } decision_t;

    function automatic level_t sym_level(symbol_t s);
        return level_t'(2 * int'(s) - 3);
    endfunction

endpackage

/* design/path_select.sv */
`timescale 1ns/1ps

module path_select #(
    parameter int N = 4,                 // at least two candidates.
    parameter type payload_t = logic
) (
    input  logic [N-1:0][mlse_cfg_pkg::ENERGY_W+$bits(payload_t)-1:0] cand,
    output mlse_types_pkg::energy_t                                   best_energy,
    output payload_t                                                  best_payload,
    output logic [$clog2(N)-1:0]                                      best_index
);

    localparam int IDX_W  = $clog2(N);
    localparam int LEAVES = 1 << IDX_W;

    typedef struct packed {
        mlse_types_pkg::energy_t energy;
        payload_t                payload;
    } cand_t;

    always_comb begin : l_tree
        cand_t            node     [2*LEAVES-1];
        logic [IDX_W-1:0] node_idx [2*LEAVES-1];

        // leaves sit at the tail of a heap ordered array.
        for (int k = 0; k < LEAVES; k++) begin
            if (k < N) begin
                node[LEAVES-1+k] = cand[k];
            end else begin
                node[LEAVES-1+k] = {mlse_cfg_pkg::ENERGY_MAX, {$bits(payload_t){1'b0}}};
            end
            node_idx[LEAVES-1+k] = IDX_W'(k);
        end

        // each node keeps its left child unless the right one is strictly lower.
        // the left child always covers the lower indices, so ties go to the lower index.
        for (int j = LEAVES - 2; j >= 0; j--) begin
            if (node[2*j+2].energy < node[2*j+1].energy) begin
                node[j]     = node[2*j+2];
                node_idx[j] = node_idx[2*j+2];
            end else begin
                node[j]     = node[2*j+1];
                node_idx[j] = node_idx[2*j+1];
            end
        end

        best_energy  = node[0].energy;
        best_payload = node[0].payload;
        best_index   = node_idx[0];
    end

endmodule

/* design/channel_conv.sv */
`timescale 1ns/1ps

module channel_conv (
    input  mlse_types_pkg::symbol_t [mlse_cfg_pkg::N_TAPS-1:0] hist,
    input  mlse_types_pkg::chan_est_t                          chan,
    output mlse_types_pkg::sample_t                            expected
);

    localparam int PROD_W = mlse_cfg_pkg::LEVEL_W + mlse_cfg_pkg::TAP_W;

    logic signed [PROD_W-1:0] prod [mlse_cfg_pkg::N_TAPS];

    // tap t weights the symbol sent t samples before the newest one.
    for (genvar t = 0; t < mlse_cfg_pkg::N_TAPS; t++) begin : g_tap
        mlse_types_pkg::level_t level;

        assign level   = mlse_types_pkg::sym_level(hist[t]);
        assign prod[t] = PROD_W'(level) * PROD_W'(chan[t]);
    end

    always_comb begin : l_sum
        logic signed [mlse_cfg_pkg::SAMPLE_W-1:0] acc;

        acc = '0;
        for (int t = 0; t < mlse_cfg_pkg::N_TAPS; t++) begin
            acc = acc + mlse_cfg_pkg::SAMPLE_W'(prod[t]); // sign extended.
        end
        expected = acc;
    end

endmodule

/* design/branch_metric.sv */
`timescale 1ns/1ps

module branch_metric (
    input  mlse_types_pkg::sample_t                               sample,
    input  mlse_types_pkg::chan_est_t                             chan,
    input  mlse_types_pkg::path_t [mlse_cfg_pkg::N_STATES-1:0]    state_path,
    output mlse_types_pkg::path_t [mlse_cfg_pkg::N_SYM*mlse_cfg_pkg::N_STATES-1:0] cand
);

    localparam int NS     = mlse_cfg_pkg::N_STATES;
    localparam int DIFF_W = mlse_cfg_pkg::SAMPLE_W + 1;
    localparam int SQ_W   = 2 * DIFF_W;
    localparam int SUM_W  = ((SQ_W > mlse_cfg_pkg::ENERGY_W) ? SQ_W : mlse_cfg_pkg::ENERGY_W) + 1;
    localparam int HD     = mlse_cfg_pkg::HIST_DEPTH;

    // with two taps a state is just the last symbol, so the new symbol names the destination.
    // candidates are grouped per destination as cand[d*NS + s].
    for (genvar d = 0; d < mlse_cfg_pkg::N_SYM; d++) begin : g_dst
        for (genvar s = 0; s < NS; s++) begin : g_src
            mlse_types_pkg::sample_t  expected;
            logic signed [DIFF_W-1:0] diff;
            logic [SQ_W-1:0]          sq;
            logic [SUM_W-1:0]         sum;
            mlse_types_pkg::energy_t  energy;

            channel_conv u_conv (
                .hist     ({mlse_types_pkg::symbol_t'(s), mlse_types_pkg::symbol_t'(d)}),
                .chan     (chan),
                .expected (expected)
            );

            assign diff = DIFF_W'(sample) - DIFF_W'(expected);
            assign sq   = SQ_W'(diff) * SQ_W'(diff);
            assign sum  = SUM_W'(state_path[s].energy) + SUM_W'(sq);

            // saturate so that a starting state at the ceiling never wraps to a low energy.
            assign energy = (sum > SUM_W'(mlse_cfg_pkg::ENERGY_MAX)) ?
                            mlse_cfg_pkg::ENERGY_MAX : sum[mlse_cfg_pkg::ENERGY_W-1:0];

            assign cand[d*NS+s] = '{
                energy: energy,
                hist:   {state_path[s].hist[HD-2:0], mlse_types_pkg::symbol_t'(d)},
                src:    mlse_types_pkg::symbol_t'(s)
            };
        end
    end

endmodule

/* design/trellis_state.sv */
`timescale 1ns/1ps

module trellis_state #(
    parameter int STATE_INDEX = 0
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              sample_valid,
    input  logic                                              restart,
    input  mlse_types_pkg::path_t [mlse_cfg_pkg::N_STATES-1:0] cand,
    input  mlse_types_pkg::energy_t                           norm_energy,
    output mlse_types_pkg::path_t                             state_path
);

    // only state 0 is a plausible start. The others begin at the ceiling.
    localparam mlse_types_pkg::energy_t INIT_ENERGY =
        (STATE_INDEX == 0) ? mlse_types_pkg::energy_t'(0) : mlse_cfg_pkg::ENERGY_MAX;

    localparam mlse_types_pkg::path_t INIT_PATH = '{
        energy: INIT_ENERGY,
        hist:   '0,
        src:    '0
    };

    mlse_types_pkg::energy_t   win_energy;
    mlse_types_pkg::survivor_t win_surv;
    mlse_types_pkg::energy_t   norm_next;
    mlse_types_pkg::path_t     path_q;

    path_select #(
        .N         (mlse_cfg_pkg::N_STATES),
        .payload_t (mlse_types_pkg::survivor_t)
    ) u_acs_select (
        .cand         (cand),
        .best_energy  (win_energy),
        .best_payload (win_surv),
        .best_index   ()
    );

    // norm_energy is the lowest energy of the previous step, so every winner sits at or above it.
    assign norm_next = win_energy - norm_energy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            path_q <= INIT_PATH;
        end else if (restart) begin
            path_q <= INIT_PATH; // new channel, new trellis.
        end else if (sample_valid) begin
            path_q.energy <= norm_next;
            path_q.hist   <= win_surv.hist;
            path_q.src    <= win_surv.src;
        end
    end

    assign state_path = path_q;

endmodule

/* design/mlse_equalizer.sv */
`timescale 1ns/1ps

module mlse_equalizer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      chan_load,
    input  mlse_types_pkg::chan_est_t chan,
    input  logic                      sample_valid,
    input  mlse_types_pkg::sample_t   sample,
    output logic                      decision_valid,
    output mlse_types_pkg::decision_t decision
);

    localparam int NS     = mlse_cfg_pkg::N_STATES;
    localparam int FILL_W = mlse_cfg_pkg::FILL_W;
    localparam int SEL_W  = mlse_cfg_pkg::ENERGY_W + mlse_cfg_pkg::SYM_BITS;

    mlse_types_pkg::chan_est_t                         chan_q;
    mlse_types_pkg::path_t [NS-1:0]                    state_path;
    mlse_types_pkg::path_t [mlse_cfg_pkg::N_SYM*NS-1:0] cand;
    logic [NS-1:0][SEL_W-1:0]                          best_cand;
    mlse_types_pkg::energy_t                           best_energy;
    mlse_types_pkg::symbol_t                           best_state;
    logic [FILL_W-1:0]                                 fill_cnt;
    logic                                              fill_done;
    logic                                              decide_pend;

    always_ff @(posedge clk) begin
        if (chan_load) begin
            chan_q <= chan;
        end
    end

    branch_metric u_branch_metric (
        .sample     (sample),
        .chan       (chan_q),
        .state_path (state_path),
        .cand       (cand)
    );

    for (genvar d = 0; d < NS; d++) begin : g_state
        trellis_state #(
            .STATE_INDEX (d)
        ) u_state (
            .clk          (clk),
            .rst_n        (rst_n),
            .sample_valid (sample_valid),
            .restart      (chan_load),
            .cand         (cand[d*NS +: NS]),
            .norm_energy  (best_energy),
            .state_path   (state_path[d])
        );

        assign best_cand[d] = {state_path[d].energy, mlse_types_pkg::symbol_t'(d)};
    end

    // best energy of the current paths. It also normalizes the next update.
    path_select #(
        .N         (NS),
        .payload_t (mlse_types_pkg::symbol_t)
    ) u_best_select (
        .cand         (best_cand),
        .best_energy  (best_energy),
        .best_payload (best_state),
        .best_index   ()
    );

    assign fill_done = (fill_cnt == FILL_W'(mlse_cfg_pkg::HIST_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt       <= '0;
            decide_pend    <= 1'b0;
            decision_valid <= 1'b0;
        end else begin
            // a sample that lands with chan_load is dropped along with the old paths.
            decide_pend    <= sample_valid && !chan_load && fill_done;
            decision_valid <= decide_pend;
            if (chan_load) begin
                fill_cnt <= '0;
            end else if (sample_valid && !fill_done) begin
                fill_cnt <= fill_cnt + FILL_W'(1);
            end
        end
    end

    // the paths have settled one cycle after the sample, so the decision is taken then.
    always_ff @(posedge clk) begin
        if (decide_pend) begin
            decision.sym    <= state_path[best_state].hist[mlse_cfg_pkg::HIST_DEPTH-1];
            decision.energy <= best_energy;
        end
    end

endmodule

/* testbench/tb_mlse_equalizer.sv */
`timescale 1ns/1ps

module tb_mlse_equalizer;

    localparam int HD             = mlse_cfg_pkg::HIST_DEPTH;
    localparam int N_FILL         = 40;
    localparam int N_RUN          = 200;
    localparam int N_GAP          = 100;
    localparam int TOTAL_SAMPLES  = N_FILL + 3 * N_RUN + 2 * N_GAP;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_SAMPLES + 200;

    logic                      clk;
    logic                      rst_n;
    logic                      chan_load;
    mlse_types_pkg::chan_est_t chan;
    logic                      sample_valid;
    mlse_types_pkg::sample_t   sample;
    logic                      decision_valid;
    mlse_types_pkg::decision_t decision;

    int                        taps [2];       // channel model, tap 0 on the newest symbol.
    mlse_types_pkg::symbol_t   prev_sym;
    mlse_types_pkg::symbol_t   sent_q [$];
    logic                      expect_dec;
    logic [1:0]                dec_due;
    mlse_types_pkg::decision_t exp_q [$];
    mlse_types_pkg::decision_t seen_q [$];
    mlse_types_pkg::symbol_t   pat_sym [N_GAP];
    int                        pat_noise [N_GAP];
    int                        cycle_cnt = 0;

    mlse_equalizer dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .chan_load      (chan_load),
        .chan           (chan),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .decision_valid (decision_valid),
        .decision       (decision)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // a sample taken at one edge shows its decision after the next edge.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_due <= '0;
        end else begin
            dec_due <= {dec_due[0], sample_valid && expect_dec};
        end
    end

    always @(negedge clk) begin : l_check
        mlse_types_pkg::decision_t exp_d;

        if (rst_n) begin
            check_flag(decision_valid, dec_due[1], "decision_valid");
            if (dec_due[1]) begin
                exp_d = exp_q.pop_front();
                check_decision(decision, exp_d);
                seen_q.push_back(decision);
            end
        end
    end

    function automatic int level_of(mlse_types_pkg::symbol_t s);
        case (s)
            2'd0:    return -3;
            2'd1:    return -1;
            2'd2:    return 1;
            default: return 3;
        endcase
    endfunction

    function automatic mlse_types_pkg::symbol_t random_symbol();
        return mlse_types_pkg::symbol_t'($urandom_range(3, 0));
    endfunction

    function automatic int random_noise();
        return int'($urandom_range(2, 0)) - 1; // -1, 0 or +1 LSB.
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "test aborted");
    endtask

    task automatic check_decision(input mlse_types_pkg::decision_t got,
                                  input mlse_types_pkg::decision_t exp_d);
        if (got !== exp_d) begin
            $display("** Error at time %0t: decision sym %0d energy %0d, expected sym %0d energy %0d",
                     $time, got.sym, got.energy, exp_d.sym, exp_d.energy);
            $display("Result: FAILED");
            $fatal(1, "decision mismatch");
        end
    endtask

    task automatic check_flag(input bit got, input bit exp_b, input string what);
        if (got !== exp_b) begin
            $display("** Error at time %0t: %s is %0b, expected %0b", $time, what, got, exp_b);
            $display("Result: FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic reset_dut();
        sample_valid = 1'b0;
        rst_n        = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic load_channel(input int t0, input int t1);
        @(negedge clk);
        sample_valid = 1'b0;
        chan_load    = 1'b1;
        chan[0]      = mlse_types_pkg::tap_t'(t0);
        chan[1]      = mlse_types_pkg::tap_t'(t1);
        taps[0]      = t0;
        taps[1]      = t1;
        prev_sym     = '0;  // the trellis restarts in state 0.
        sent_q.delete();
        seen_q.delete();
        @(negedge clk);
        chan_load = 1'b0;
    endtask

    task automatic send_symbol(input mlse_types_pkg::symbol_t s, input int noise);
        int                        rx;
        mlse_types_pkg::decision_t exp_d;

        @(negedge clk);
        rx           = taps[0] * level_of(s) + taps[1] * level_of(prev_sym) + noise;
        sample       = mlse_types_pkg::sample_t'(rx);
        sample_valid = 1'b1;
        prev_sym     = s;
        sent_q.push_back(s);
        expect_dec   = (sent_q.size() > HD);
        if (expect_dec) begin
            exp_d.sym = sent_q[sent_q.size() - HD]; // oldest entry of a full survivor.
            // the true path wins in every state it reaches, so only this sample's error is left.
            exp_d.energy = mlse_types_pkg::energy_t'(noise * noise);
            exp_q.push_back(exp_d);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            sample_valid = 1'b0;
        end
    endtask

    task automatic drain_decisions();
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(3); // decision_valid must stay low here.
    endtask

    task automatic expect_decision_count(input int n_sent);
        if (seen_q.size() != n_sent - HD) begin
            report_failure($sformatf("saw %0d decisions for %0d samples, expected %0d",
                                     seen_q.size(), n_sent, n_sent - HD));
        end
    endtask

    task automatic run_stream(input int n, input bit noisy);
        for (int i = 0; i < n; i++) begin
            send_symbol(random_symbol(), noisy ? random_noise() : 0);
        end
        drain_decisions();
        expect_decision_count(n);
    endtask

    task automatic run_pattern(input bit with_gaps);
        load_channel(8, 3);
        for (int i = 0; i < N_GAP; i++) begin
            send_symbol(pat_sym[i], pat_noise[i]);
            if (with_gaps) begin
                idle_cycles(int'($urandom_range(3, 0)));
            end
        end
        drain_decisions();
        expect_decision_count(N_GAP);
    endtask

    task automatic test_fill_after_reset();
        // the channel register has no reset, so the taps survive the second reset.
        load_channel(8, 3);
        reset_dut();
        run_stream(N_FILL, 1'b0);
    endtask

    task automatic test_noiseless();
        load_channel(8, 3);
        run_stream(N_RUN, 1'b0);
    endtask

    task automatic test_noisy();
        load_channel(8, 3);
        run_stream(N_RUN, 1'b1);
    endtask

    task automatic test_reload();
        load_channel(6, -4);
        run_stream(N_RUN, 1'b1);
    endtask

    task automatic test_gap_independence();
        for (int i = 0; i < N_GAP; i++) begin
            pat_sym[i]   = random_symbol();
            pat_noise[i] = random_noise();
        end
        // both runs are held against the same expected decision sequence.
        run_pattern(1'b0);
        run_pattern(1'b1);
    endtask

    initial begin : l_main
        clk          = 1'b0;
        rst_n        = 1'b0;
        chan_load    = 1'b0;
        chan         = '0;
        sample_valid = 1'b0;
        sample       = '0;
        expect_dec   = 1'b0;
        prev_sym     = '0;
        taps[0]      = 0;
        taps[1]      = 0;
        void'($urandom(97));

        reset_dut();

        test_fill_after_reset();
        test_noiseless();
        test_noisy();
        test_reload();
        test_gap_independence();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* src.f */
design/mlse_cfg_pkg.sv
design/mlse_types_pkg.sv
design/path_select.sv
design/channel_conv.sv
design/branch_metric.sv
design/trellis_state.sv
design/mlse_equalizer.sv
testbench/tb_mlse_equalizer.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mlse_equalizer
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a $fatal in the testbench makes the binary exit with a failing status.
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
